//--- common/flit_pkg.sv
// flit format with a 3-bit node field for networks of at most 8 nodes and a one-bit channel field
package flit_pkg;

	// flit type sits in the top two bits of every flit
	typedef enum logic [1:0] {
		flit_tail   = 2'b00,	// last flit of a packet and releases the channel
		flit_head   = 2'b01,	// opens a multi-flit packet
		flit_body   = 2'b10,
		flit_header = 2'b11	// whole packet in one flit
	} flit_kind_t;

	localparam int flit_vc_width = 1;	// two channels per port
	localparam int flit_payload_width = 16;
	localparam int node_width = 3;
	localparam int head_data_width = flit_payload_width - 2 * node_width;

	// routing fields of a head or header
	typedef struct packed {
		logic [node_width-1:0] dest;	// destination node
		logic [node_width-1:0] src;	// source node
		logic [head_data_width-1:0] data;	// 10 bits of packet data
	} head_fields_t;

	// one payload word seen two ways
	// head and header carry the routing fields and body or tail carry plain data
	typedef union packed {
		head_fields_t head;
		logic [flit_payload_width-1:0] body;
	} flit_payload_u;

	typedef struct packed {
		flit_kind_t kind;
		logic [flit_vc_width-1:0] vc;	// channel index at the sending node
		flit_payload_u payload;
	} flit_t;	// 19 bits in all

	// head and header both start a packet and carry a destination
	function automatic logic is_head(input flit_kind_t kind);
		return (kind == flit_head) || (kind == flit_header);
	endfunction

endpackage

//--- common/spidergon_pkg.sv
// port and direction codes of a three-port Spidergon node with exactly two channels per port
package spidergon_pkg;
	import flit_pkg::*;

	// output direction of a packet
	// the network values double as port indices
	typedef enum logic [1:0] {
		dir_anticlockwise = 2'd0,
		dir_clockwise     = 2'd1,
		dir_across        = 2'd2,
		dir_stop          = 2'd3	// packet has arrived and leaves on the cpu output
	} dir_t;

	localparam int num_ports = 3;	// anticlockwise, clockwise and across

	typedef flit_t [num_ports-1:0] port_flits_t;	// one flit per network port, 57 bits

	// on/off levels of the two channels of one port
	typedef struct packed {
		logic [1:0] ready;	// channel unreserved and empty so a new head may come
		logic [1:0] full;	// no free entry left in the channel buffer
	} vc_status_t;

endpackage

//--- design/vc_fifo.sv
// strict FIFO of flits for one virtual channel whose front is read combinationally and depth is >= 1
`timescale 1ns/1ps

module vc_fifo
	import flit_pkg::*;
#(
	parameter int depth = 2
)
(
	input  logic  clk,
	input  logic  reset,
	input  logic  wr,
	input  flit_t wr_flit,
	input  logic  rd,
	output flit_t front,
	output logic  nonempty,
	output logic  full
);
	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_width = $clog2(depth + 1);

	flit_t mem [depth];	// storage only and no reset
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [cnt_width-1:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr)
				wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;	// wrap at depth
			if (rd)
				rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr && !rd)
				count <= count + 1'b1;
			else if (rd && !wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr)
			mem[wr_ptr] <= wr_flit;
	end

	assign front = mem[rd_ptr];	// visible the cycle after its write
	assign nonempty = (count != '0);
	assign full = (count == cnt_width'(depth));

	// upstream must watch the full level and the allocator the nonempty flag
	a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr |-> !full)
		else $error("vc_fifo write while full");
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd |-> nonempty)
		else $error("vc_fifo read while empty");

endmodule

//--- input_port/input_port.sv
// one input port with vc_count channels that must equal 2**flit_vc_width and match vc_status_t
`timescale 1ns/1ps

module input_port
	import flit_pkg::*;
	import spidergon_pkg::*;
#(
	parameter int vc_count = 2,
	parameter int vc_depth = 2
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  flit_t                 in_flit,
	input  logic                  in_valid,
	input  logic [vc_count-1:0]   deq,	// one-hot read strobe from the allocator
	output flit_t [vc_count-1:0]  fronts,
	output logic [vc_count-1:0]   nonempty,
	output vc_status_t            status
);
	// reservation table, one row per local channel
	logic [vc_count-1:0] reserved;	// held from head write until tail write
	logic [flit_vc_width-1:0] prev_vc [vc_count];	// upstream channel that owns the row

	logic [vc_count-1:0] ready;
	logic [vc_count-1:0] full_vc;
	logic [vc_count-1:0] match;	// reserved rows whose prev_vc equals the incoming field
	logic [vc_count-1:0] head_sel;	// lowest ready channel
	logic [vc_count-1:0] wr_sel;	// one-hot write enable, zero when the flit is dropped

	assign ready = ~reserved & ~nonempty;
	assign head_sel = ready & (~ready + 1'b1);	// isolate lowest set bit

	// head or header takes a fresh channel and body or tail follows its owner
	assign wr_sel = !in_valid ? '0 :
		is_head(in_flit.kind) ? head_sel : (match & ~full_vc);

	for (genvar v = 0; v < vc_count; v++)
	begin : g_vc
		flit_t store_flit;

		assign match[v] = reserved[v] && (prev_vc[v] == in_flit.vc);

		// next node matches on our local channel index
		always_comb
		begin
			store_flit = in_flit;
			store_flit.vc = flit_vc_width'(v);
		end

		vc_fifo #(
			.depth(vc_depth)
		) u_fifo (
			.clk(clk),
			.reset(reset),
			.wr(wr_sel[v]),
			.wr_flit(store_flit),
			.rd(deq[v]),
			.front(fronts[v]),
			.nonempty(nonempty[v]),
			.full(full_vc[v])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			reserved <= '0;
		else
			for (int v = 0; v < vc_count; v++)
				if (wr_sel[v])
				begin
					if (in_flit.kind == flit_head)
						reserved[v] <= 1'b1;	// header never holds the row past its write
					else if (in_flit.kind == flit_tail)
						reserved[v] <= 1'b0;	// tail is stored then the row frees
				end
	end

	// owner tag only read while the row is reserved
	always_ff @(posedge clk)
	begin
		for (int v = 0; v < vc_count; v++)
			if (wr_sel[v] && is_head(in_flit.kind))
				prev_vc[v] <= in_flit.vc;
	end

	assign status.ready = ready;
	assign status.full = full_vc;

	// upstream broke the on/off rules so the flit is lost
	a_flit_accepted: assert property (@(posedge clk) disable iff (reset) in_valid |-> |wr_sel)
		else $error("input_port dropped flit of kind %0d vc %0d", in_flit.kind, in_flit.vc);
	a_vc_count: assert property (@(posedge clk) vc_count == (1 << flit_vc_width))
		else $error("vc_count %0d does not fit the flit channel field", vc_count);

endmodule

//--- switch/switch_allocator.sv
// routes by relative distance for at most 8 nodes and holds an output until the packet tail leaves
`timescale 1ns/1ps

module switch_allocator
	import flit_pkg::*;
	import spidergon_pkg::*;
#(
	parameter int num_nodes = 8,
	parameter int node_id = 0,
	parameter int vc_count = 2
)
(
	input  logic                                  clk,
	input  logic                                  reset,
	input  flit_t [num_ports-1:0][vc_count-1:0]   fronts,
	input  logic [num_ports-1:0][vc_count-1:0]    nonempty,
	input  vc_status_t [num_ports-1:0]            nbr_status,
	output logic [num_ports-1:0][vc_count-1:0]    deq,
	output port_flits_t                           sel_flits,
	output logic [num_ports-1:0]                  sel_valid,
	output flit_t                                 sel_cpu_flit,
	output logic                                  sel_cpu_valid
);
	localparam int total = num_ports * vc_count;	// candidates at port*vc_count+vc
	localparam int idx_width = $clog2(total);
	localparam int num_outs = num_ports + 1;	// cpu sits at index dir_stop

	flit_t cand_flit [total];
	logic [total-1:0] cand_live;
	dir_t route_now [total];
	dir_t route_q [total];	// direction of the packet in flight per channel
	logic [num_outs-1:0][total-1:0] req;
	logic [num_outs-1:0][total-1:0] gnt;
	logic [total-1:0] taken;
	logic [num_outs-1:0] can_send;
	logic [num_outs-1:0] locked;	// wormhole lock per output
	logic [idx_width-1:0] lock_idx [num_outs];
	logic [idx_width-1:0] rr_ptr [num_outs];	// first candidate to try when free
	logic [num_outs-1:0] pick_valid;
	logic [idx_width-1:0] pick_idx [num_outs];

	function automatic dir_t route_of(input logic [node_width-1:0] dest);
		int rel;
		rel = (int'(dest) + num_nodes - node_id) % num_nodes;
		if (rel == 0)
			return dir_stop;
		else if (rel <= num_nodes / 4)
			return dir_clockwise;
		else if (rel >= 3 * num_nodes / 4)
			return dir_anticlockwise;
		return dir_across;
	endfunction

	always_comb
	begin
		for (int p = 0; p < num_ports; p++)
			for (int v = 0; v < vc_count; v++)
			begin
				cand_flit[p*vc_count+v] = fronts[p][v];
				cand_live[p*vc_count+v] = nonempty[p][v];
				deq[p][v] = taken[p*vc_count+v];
			end
	end

	// heads route from the destination and later flits reuse the stored route
	always_comb
	begin
		for (int i = 0; i < total; i++)
		begin
			route_now[i] = is_head(cand_flit[i].kind) ?
				route_of(cand_flit[i].payload.head.dest) : route_q[i];
			for (int o = 0; o < num_outs; o++)
				req[o][i] = cand_live[i] && (route_now[i] == dir_t'(o));
		end
	end

	always_comb
	begin
		for (int o = 0; o < num_ports; o++)	// neighbour has a free channel or a reserved one with room
			can_send[o] = (|nbr_status[o].ready) || (|(~nbr_status[o].ready & ~nbr_status[o].full));
		can_send[num_ports] = 1'b1;	// cpu never stalls
	end

	always_comb
	begin
		logic [idx_width-1:0] cand;
		cand = '0;
		for (int o = 0; o < num_outs; o++)
		begin
			pick_valid[o] = 1'b0;
			pick_idx[o] = lock_idx[o];
			if (locked[o])
				pick_valid[o] = req[o][lock_idx[o]] && can_send[o];	// owner only
			else
				for (int k = total - 1; k >= 0; k--)	// lowest offset from rr_ptr wins
				begin
					cand = idx_width'((rr_ptr[o] + k) % total);
					if (req[o][cand] && is_head(cand_flit[cand].kind) && can_send[o])
					begin
						pick_valid[o] = 1'b1;
						pick_idx[o] = cand;
					end
				end
		end
	end

	always_comb
	begin
		taken = '0;
		for (int o = 0; o < num_outs; o++)
		begin
			gnt[o] = '0;
			if (pick_valid[o])
				gnt[o][pick_idx[o]] = 1'b1;
			taken = taken | gnt[o];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			locked <= '0;
			for (int o = 0; o < num_outs; o++)
			begin
				lock_idx[o] <= '0;
				rr_ptr[o] <= '0;	// channel 0 of port 0
			end
			for (int i = 0; i < total; i++)
				route_q[i] <= dir_stop;
		end
		else
		begin
			for (int o = 0; o < num_outs; o++)
				if (pick_valid[o])
				begin
					if (cand_flit[pick_idx[o]].kind == flit_head)
					begin
						locked[o] <= 1'b1;
						lock_idx[o] <= pick_idx[o];
					end
					else if (cand_flit[pick_idx[o]].kind == flit_tail)
						locked[o] <= 1'b0;
					if (!locked[o])	// pointer moves past the winner of a free output
						rr_ptr[o] <= (pick_idx[o] == idx_width'(total - 1)) ? '0 : pick_idx[o] + 1'b1;
				end
			for (int i = 0; i < total; i++)
				if (taken[i] && is_head(cand_flit[i].kind))
					route_q[i] <= route_now[i];
		end
	end

	always_comb
	begin
		for (int o = 0; o < num_ports; o++)
		begin
			sel_flits[o] = cand_flit[pick_idx[o]];
			sel_valid[o] = pick_valid[o];
		end
	end

	assign sel_cpu_flit = cand_flit[pick_idx[num_ports]];
	assign sel_cpu_valid = pick_valid[num_ports];

	// a body or tail at a channel front still owns the output its head locked
	for (genvar i = 0; i < total; i++)
	begin : g_owner
		a_body_owns_lock: assert property (@(posedge clk) disable iff (reset)
			(cand_live[i] && (cand_flit[i].kind == flit_body || cand_flit[i].kind == flit_tail))
				|-> (locked[route_q[i]] && (lock_idx[route_q[i]] == idx_width'(i))))
			else $error("channel %0d front is a body or tail without its output lock", i);
	end

endmodule

//--- design/output_stage.sv
// output registers of the node where flit data is only loaded with a valid and holds otherwise
`timescale 1ns/1ps

module output_stage
	import flit_pkg::*;
	import spidergon_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  port_flits_t          sel_flits,
	input  logic [num_ports-1:0] sel_valid,
	input  flit_t                sel_cpu_flit,
	input  logic                 sel_cpu_valid,
	output port_flits_t          out_flits,
	output logic [num_ports-1:0] out_valid,	// one-cycle strobe per network port
	output flit_t                cpu_flit,
	output logic                 cpu_valid
);

	// valid strobes are control state and clear on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= '0;
			cpu_valid <= 1'b0;
		end
		else
		begin
			out_valid <= sel_valid;
			cpu_valid <= sel_cpu_valid;
		end
	end

	// data lines keep their last value between flits to cut toggling
	always_ff @(posedge clk)
	begin
		for (int o = 0; o < num_ports; o++)
			if (sel_valid[o])
				out_flits[o] <= sel_flits[o];
		if (sel_cpu_valid)
			cpu_flit <= sel_cpu_flit;	// local delivery
	end

endmodule

//--- design/spidergon_node.sv
// one Spidergon router node with num_nodes <= 8 and vc_count fixed at 2 by the flit format
`timescale 1ns/1ps

module spidergon_node
	import flit_pkg::*;
	import spidergon_pkg::*;
#(
	parameter int num_nodes = 8,
	parameter int node_id = 0,
	parameter int vc_count = 2,
	parameter int vc_depth = 2	// flits per channel buffer
)
(
	input  logic                        clk,
	input  logic                        reset,
	input  port_flits_t                 in_flits,
	input  logic [num_ports-1:0]        in_valid,
	input  vc_status_t [num_ports-1:0]  nbr_status,	// levels of the neighbour on each output
	output vc_status_t [num_ports-1:0]  node_status,	// own levels seen by upstream
	output port_flits_t                 out_flits,
	output logic [num_ports-1:0]        out_valid,
	output flit_t                       cpu_flit,
	output logic                        cpu_valid
);
	flit_t [num_ports-1:0][vc_count-1:0] port_fronts;
	logic [num_ports-1:0][vc_count-1:0] port_nonempty;
	logic [num_ports-1:0][vc_count-1:0] port_deq;
	port_flits_t sel_flits;
	logic [num_ports-1:0] sel_valid;
	flit_t sel_cpu_flit;
	logic sel_cpu_valid;

	// stage 1 buffers per input port
	for (genvar p = 0; p < num_ports; p++)
	begin : g_port
		input_port #(
			.vc_count(vc_count),
			.vc_depth(vc_depth)
		) u_input_port (
			.clk(clk),
			.reset(reset),
			.in_flit(in_flits[p]),
			.in_valid(in_valid[p]),
			.deq(port_deq[p]),
			.fronts(port_fronts[p]),
			.nonempty(port_nonempty[p]),
			.status(node_status[p])
		);
	end

	// stage 2 route and arbitrate
	switch_allocator #(
		.num_nodes(num_nodes),
		.node_id(node_id),
		.vc_count(vc_count)
	) u_switch_allocator (
		.clk(clk),
		.reset(reset),
		.fronts(port_fronts),
		.nonempty(port_nonempty),
		.nbr_status(nbr_status),
		.deq(port_deq),
		.sel_flits(sel_flits),
		.sel_valid(sel_valid),
		.sel_cpu_flit(sel_cpu_flit),
		.sel_cpu_valid(sel_cpu_valid)
	);

	// stage 3 registered outputs
	output_stage u_output_stage (
		.clk(clk),
		.reset(reset),
		.sel_flits(sel_flits),
		.sel_valid(sel_valid),
		.sel_cpu_flit(sel_cpu_flit),
		.sel_cpu_valid(sel_cpu_valid),
		.out_flits(out_flits),
		.out_valid(out_valid),
		.cpu_flit(cpu_flit),
		.cpu_valid(cpu_valid)
	);

endmodule

//--- testbench/packet_scoreboard.svh
// model for node 0 of an 8-node ring, at most 1024 packets per run as the id rides in the 10 head data bits
`ifndef PACKET_SCOREBOARD_SVH
`define PACKET_SCOREBOARD_SVH

localparam int max_packets = 1024;
localparam int cpu_out = 3;	// output index of local delivery

int exp_out [max_packets];	// 0 anticlockwise, 1 clockwise, 2 across, 3 cpu
int exp_vc [max_packets];	// -1 until the local channel is known
int exp_nbody [max_packets];	// -1 marks a single-flit header
logic [15:0] exp_head [max_packets];
bit delivered [max_packets];
int open_id [4] = '{default: -1};	// packet in progress per output
int open_idx [4];	// next body index of that packet
int delivered_count = 0;

// spidergon rule by relative distance
function automatic int expected_output(input logic [2:0] dest);
	int rel;
	rel = (int'(dest) - node_id + num_nodes) % num_nodes;
	if (rel == 0)
		return cpu_out;
	if (rel <= num_nodes / 4)
		return 1;	// clockwise quarter
	if (rel >= 3 * num_nodes / 4)
		return 0;	// anticlockwise quarter
	return 2;
endfunction

// body and tail data derived from packet id and flit index
function automatic logic [15:0] body_word(input int id, input int idx);
	return 16'((id * 613 + idx * 4099) ^ 16'ha5c3);
endfunction

// a new head lands in the lowest free channel
function automatic int lowest_ready(input logic [1:0] ready);
	if (ready[0])
		return 0;
	if (ready[1])
		return 1;
	return -1;
endfunction

task automatic finish_packet(input int id);
	delivered[id] = 1;
	delivered_count++;
endtask

// wormhole reassembly per output
task automatic check_flit(input int o, input flit_t f);
	string sig;
	int id;
	flit_kind_t want;
	if (o == cpu_out)
		sig = "cpu_flit";
	else
		sig = $sformatf("out_flits[%0d]", o);
	if (open_id[o] < 0)
	begin
		id = int'(f.payload.head.data);	// id sits in the head data
		if (f.kind != flit_head && f.kind != flit_header)
		begin
			$display("%s carried a flit of kind %0d outside any packet", sig, f.kind);
			errors++;
			return;
		end
		if (id >= next_id || delivered[id])
		begin
			$display("%s carried packet %0d that was never sent or was already delivered", sig, id);
			errors++;
			return;
		end
		want = (exp_nbody[id] < 0) ? flit_header : flit_head;
		if (o != exp_out[id])
		begin
			$display("ERROR output of packet %0d expected %h got %h", id, exp_out[id], o);
			errors++;
		end
		if (f.kind != want)
		begin
			$display("ERROR %s.kind expected %h got %h", sig, want, f.kind);
			errors++;
		end
		if (f.payload.body != exp_head[id])
		begin
			$display("ERROR %s.payload expected %h got %h", sig, exp_head[id], f.payload.body);
			errors++;
		end
		if (int'(f.vc) != exp_vc[id])
		begin
			$display("ERROR %s.vc expected %h got %h", sig, exp_vc[id], f.vc);
			errors++;
		end
		if (f.kind == flit_header)
			finish_packet(id);
		else
		begin
			open_id[o] = id;	// output now belongs to this packet
			open_idx[o] = 0;
		end
	end
	else
	begin
		id = open_id[o];
		want = (open_idx[o] < exp_nbody[id]) ? flit_body : flit_tail;
		if (f.kind != want)
		begin
			$display("ERROR %s.kind expected %h got %h", sig, want, f.kind);
			errors++;
		end
		if (int'(f.vc) != exp_vc[id])	// constant within the packet
		begin
			$display("ERROR %s.vc expected %h got %h", sig, exp_vc[id], f.vc);
			errors++;
		end
		if (f.payload.body != body_word(id, open_idx[o]))
		begin
			$display("ERROR %s.payload expected %h got %h", sig,
				body_word(id, open_idx[o]), f.payload.body);
			errors++;
		end
		open_idx[o]++;
		if (want == flit_tail)
		begin
			finish_packet(id);
			open_id[o] = -1;
		end
	end
endtask

`endif

//--- testbench/tb_spidergon_node.sv
// node 0 of 8, one packet in flight per input port and an idle cycle after each flit so the levels catch up
`timescale 1ns/1ps

module tb_spidergon_node
	import flit_pkg::*;
	import spidergon_pkg::*;
();
	localparam int num_nodes = 8;
	localparam int node_id = 0;
	localparam int packets_per_port = 40;
	localparam int send_timeout = 20000;	// cycles
	localparam int drain_timeout = 2000;

	logic clk;
	logic reset;
	port_flits_t in_flits;
	logic [num_ports-1:0] in_valid;
	vc_status_t [num_ports-1:0] nbr_status;
	vc_status_t [num_ports-1:0] node_status;
	port_flits_t out_flits;
	logic [num_ports-1:0] out_valid;
	flit_t cpu_flit;
	logic cpu_valid;

	logic [31:0] rng_state = 32'h9bdf;
	int errors = 0;
	int next_id = 0;
	int sent_count = 0;
	bit [num_ports-1:0] may_send;	// neighbour levels of the last cycle allowed a flit

	// upstream sender state per input port
	int left [num_ports];	// packets still to start
	int cur_id [num_ports];
	int nbody [num_ports];
	int idx [num_ports];	// next body index
	int gap [num_ports];	// idle cycles before the next packet
	int local_vc [num_ports];	// channel the packet landed in
	logic up_vc [num_ports];	// our own channel field for the packet
	bit in_pkt [num_ports];
	bit prev_sent [num_ports];
	bit pending_pred [num_ports];	// head went out last cycle

	`include "packet_scoreboard.svh"

	spidergon_node #(
		.num_nodes(num_nodes),
		.node_id(node_id),
		.vc_count(2),
		.vc_depth(2)
	) dut (
		.clk(clk),
		.reset(reset),
		.in_flits(in_flits),
		.in_valid(in_valid),
		.nbr_status(nbr_status),
		.node_status(node_status),
		.out_flits(out_flits),
		.out_valid(out_valid),
		.cpu_flit(cpu_flit),
		.cpu_valid(cpu_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic bit sending_active();
		bit active;
		active = 0;
		for (int p = 0; p < num_ports; p++)
			if (left[p] > 0 || in_pkt[p] || pending_pred[p])
				active = 1;
		return active;
	endfunction

	task automatic drive_neighbours();
		logic [31:0] r;
		for (int o = 0; o < num_ports; o++)
		begin
			r = next_random();
			if (r[7:5] == 3'd0)
				nbr_status[o] <= 4'b0011;	// every channel reserved and full
			else
				nbr_status[o] <= r[3:0];
		end
	endtask

	// one cycle of one upstream sender, levels sampled before the edge updates them
	task automatic step_port(input int p);
		flit_t f;
		logic [31:0] r;
		bit send;
		int v;
		r = next_random();
		send = 0;
		f = '0;
		if (pending_pred[p])
		begin
			pending_pred[p] = 0;
			v = lowest_ready(node_status[p].ready);	// levels of the cycle the head was on the port
			if (v < 0)
			begin
				$display("no channel of port %0d was ready while packet %0d arrived", p, cur_id[p]);
				errors++;
				v = 0;
			end
			local_vc[p] = v;
			exp_vc[cur_id[p]] = v;
		end
		if (!prev_sent[p])
		begin
			if (in_pkt[p])
			begin
				if (!node_status[p].full[local_vc[p]])
				begin
					f.kind = (idx[p] < nbody[p]) ? flit_body : flit_tail;
					f.vc = up_vc[p];
					f.payload.body = body_word(cur_id[p], idx[p]);
					idx[p]++;
					send = 1;
					if (f.kind == flit_tail)
						in_pkt[p] = 0;
				end
			end
			else if (gap[p] > 0)
				gap[p]--;
			else if (left[p] > 0 && (|node_status[p].ready))
			begin
				cur_id[p] = next_id;
				next_id++;
				up_vc[p] = r[8];
				nbody[p] = (r[5:3] < 3'd2) ? -1 : int'(r[7:6]);	// header or 0..3 bodies
				f.kind = (nbody[p] < 0) ? flit_header : flit_head;
				f.vc = up_vc[p];
				f.payload.head.dest = r[2:0];
				f.payload.head.src = 3'(p);
				f.payload.head.data = 10'(cur_id[p]);
				exp_head[cur_id[p]] = f.payload.body;
				exp_out[cur_id[p]] = expected_output(r[2:0]);
				exp_nbody[cur_id[p]] = nbody[p];
				exp_vc[cur_id[p]] = -1;
				in_pkt[p] = (nbody[p] >= 0);
				idx[p] = 0;
				gap[p] = int'(r[10:9]);
				pending_pred[p] = 1;
				left[p]--;
				sent_count++;
				send = 1;
			end
		end
		in_valid[p] <= send;
		if (send)
			in_flits[p] <= f;
		prev_sent[p] = send;
	endtask

	// output checks, valid sampled one cycle after the levels it answers to
	always @(posedge clk)
	begin
		if (reset)
			may_send = '1;
		else
		begin
			for (int o = 0; o < num_ports; o++)
				if (out_valid[o] === 1'b1)
				begin
					if (!may_send[o])
					begin
						$display("output %0d sent a flit after its neighbour levels forbade it", o);
						errors++;
					end
					check_flit(o, out_flits[o]);
				end
			if (cpu_valid === 1'b1)
				check_flit(cpu_out, cpu_flit);
			for (int o = 0; o < num_ports; o++)
				may_send[o] = !((nbr_status[o].ready == 2'b00) && (nbr_status[o].full == 2'b11));
		end
	end

	initial
	begin
		int cycles;
		in_flits = '0;
		in_valid = '0;
		nbr_status = {num_ports{4'b1100}};	// all ready, none full
		reset = 1'b1;
		for (int p = 0; p < num_ports; p++)
		begin
			left[p] = packets_per_port;
			in_pkt[p] = 0;
			gap[p] = 0;
			prev_sent[p] = 0;
			pending_pred[p] = 0;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		if (out_valid !== 3'b000)
		begin
			$display("ERROR out_valid expected %h got %h", 3'b000, out_valid);
			errors++;
		end
		if (cpu_valid !== 1'b0)
		begin
			$display("ERROR cpu_valid expected %h got %h", 1'b0, cpu_valid);
			errors++;
		end
		for (int p = 0; p < num_ports; p++)
			if (node_status[p] !== 4'b1100)
			begin
				$display("ERROR node_status[%0d] expected %h got %h", p, 4'hc, node_status[p]);
				errors++;
			end
		cycles = 0;
		while (sending_active() && cycles < send_timeout)
		begin
			@(posedge clk);
			cycles++;
			drive_neighbours();
			for (int p = 0; p < num_ports; p++)
				step_port(p);
		end
		if (sending_active())
		begin
			$display("timeout while the upstream ports were still sending packets");
			errors++;
		end
		cycles = 0;
		while (delivered_count < sent_count && cycles < drain_timeout)
		begin
			@(posedge clk);
			cycles++;
			in_valid <= '0;
			drive_neighbours();
		end
		@(negedge clk);	// let the last edge's checks settle
		if (delivered_count < sent_count)
		begin
			$display("timeout with %0d of %0d packets delivered", delivered_count, sent_count);
			errors++;
		end
		$display("packets sent %0d delivered %0d errors %0d", sent_count, delivered_count, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- flist.f
common/flit_pkg.sv
common/spidergon_pkg.sv
design/vc_fifo.sv
input_port/input_port.sv
switch/switch_allocator.sv
design/output_stage.sv
design/spidergon_node.sv
+incdir+testbench
testbench/tb_spidergon_node.sv
